//--- alu_exec.sv
`include "alu_iq_config.svh"

module alu_exec
    import alu_iq_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    flush_i,
    input  iq_vec_t                 issue_i,
    input  logic                    advance_i,
    input  exec_t [`IQ_SIZE-1:0]    payload_i,
    output rob_id_t                 wkup_tag_o,
    output result_t                 result_o
);

    exec_t   issue_sel;
    exec_t   exec_q;
    word_t   alu_out;
    result_t result_q;

    // ----------------------------------------------------------
    // issue mux
    // ----------------------------------------------------------
    always_comb begin
        issue_sel = '0;
        for (int i = 0; i < `IQ_SIZE; i++) begin
            if (issue_i[i]) begin
                issue_sel = issue_sel | payload_i[i];
            end
        end
    end

    // early wakeup tag, same cycle as issue
    assign wkup_tag_o = issue_sel.dst;

    // ----------------------------------------------------------
    // execute stage
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            exec_q <= '0;
        end else if (advance_i) begin
            exec_q <= issue_sel;
        end
    end

    always_comb begin
        case (exec_q.op)
            ALU_ADD: alu_out = exec_q.opa + exec_q.opb;
            ALU_SUB: alu_out = exec_q.opa - exec_q.opb;
            ALU_AND: alu_out = exec_q.opa & exec_q.opb;
            ALU_OR:  alu_out = exec_q.opa | exec_q.opb;
            ALU_XOR: alu_out = exec_q.opa ^ exec_q.opb;
            // shift amount is the low 5 bits
            ALU_SLL: alu_out = exec_q.opa << exec_q.opb[4:0];
            ALU_SRL: alu_out = exec_q.opa >> exec_q.opb[4:0];
            ALU_SLT: alu_out = word_t'($signed(exec_q.opa) < $signed(exec_q.opb));
            default: alu_out = '0;
        endcase
    end

    // ----------------------------------------------------------
    // result stage
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            result_q <= '0;
        end else if (advance_i) begin
            result_q.dst  <= exec_q.dst;
            result_q.data <= alu_out;
        end
    end

    assign result_o = result_q;

endmodule

//--- alu_iq_config.svh
`ifndef ALU_IQ_CONFIG_SVH
`define ALU_IQ_CONFIG_SVH

// ----------------------------------------------------------
// queue geometry
// ----------------------------------------------------------
`define IQ_SIZE 4

// broadcast ports feeding operand capture
`define CDB_COUNT 2

// ----------------------------------------------------------
// datapath widths
// ----------------------------------------------------------
`define DATA_W 32

// tag space of the reorder buffer
`define ROB_ID_W 5

`endif

//--- alu_iq_ctrl.sv
`include "alu_iq_config.svh"

module alu_iq_ctrl
    import alu_iq_pkg::*;
(
    input  logic    clk,
    input  logic    reset_i,
    input  logic    flush_i,
    input  logic    dispatch_valid_i,
    input  logic    fifo_ready_i,
    input  iq_vec_t valid_i,
    input  iq_vec_t grant_i,
    output iq_vec_t alloc_o,
    output iq_vec_t issue_o,
    output logic    advance_o,
    output logic    dispatch_ready_o,
    output logic    wkup_valid_o,
    output logic    result_valid_o
);

    iq_vec_t free_vec;
    iq_vec_t lowest_free;
    logic    exec_valid_q;
    logic    result_valid_q;

    // ----------------------------------------------------------
    // slot allocation
    // ----------------------------------------------------------
    assign free_vec    = ~valid_i;

    // isolate lowest set bit
    assign lowest_free = free_vec & (~free_vec + iq_vec_t'(1));

    assign alloc_o          = dispatch_valid_i ? lowest_free : '0;
    assign dispatch_ready_o = |free_vec;

    // ----------------------------------------------------------
    // pipe advance and issue
    // ----------------------------------------------------------
    assign advance_o = !result_valid_q || fifo_ready_i;

    // no issue while flushing, the slot is dropped anyway
    assign issue_o      = (advance_o && !flush_i) ? grant_i : '0;
    assign wkup_valid_o = |issue_o;

    // exec and result valid bits
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            exec_valid_q   <= 1'b0;
            result_valid_q <= 1'b0;
        end else if (advance_o) begin
            exec_valid_q   <= |issue_o;
            result_valid_q <= exec_valid_q;
        end
    end

    assign result_valid_o = result_valid_q;

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------

    // source must respect the ready level
    a_dispatch_ready: assert property (
        @(posedge clk) disable iff (reset_i)
        dispatch_valid_i |-> dispatch_ready_o
    );

endmodule

//--- alu_iq_pkg.sv
`include "alu_iq_config.svh"

package alu_iq_pkg;

    // ----------------------------------------------------------
    // basic vectors
    // ----------------------------------------------------------
    typedef logic [`DATA_W-1:0]   word_t;
    typedef logic [`ROB_ID_W-1:0] rob_id_t;
    typedef logic [2:0]           alu_op_t;
    typedef logic [`IQ_SIZE-1:0]  iq_vec_t;

    // alu opcodes
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;
    localparam alu_op_t ALU_SLL = 3'd5;
    localparam alu_op_t ALU_SRL = 3'd6;
    localparam alu_op_t ALU_SLT = 3'd7;

    // ----------------------------------------------------------
    // bundles
    // ----------------------------------------------------------
    typedef struct packed {
        alu_op_t          op;
        rob_id_t          dst;
        rob_id_t [1:0]    src_tag;
        word_t   [1:0]    src_val;
        logic    [1:0]    src_valid;
    } dispatch_t;

    typedef struct packed {
        logic    valid;
        rob_id_t tag;
        word_t   data;
    } cdb_t;

    // what a slot hands to the execute pipe
    typedef struct packed {
        alu_op_t op;
        rob_id_t dst;
        word_t   opa;
        word_t   opb;
    } exec_t;

    typedef struct packed {
        rob_id_t dst;
        word_t   data;
    } result_t;

endpackage

//--- alu_iq_top.sv
`include "alu_iq_config.svh"

module alu_iq_top
    import alu_iq_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    flush_i,
    input  logic                    dispatch_valid_i,
    input  dispatch_t               dispatch_i,
    output logic                    dispatch_ready_o,
    input  cdb_t [`CDB_COUNT-1:0]   cdb_i,
    output logic                    wkup_valid_o,
    output rob_id_t                 wkup_tag_o,
    output logic                    result_valid_o,
    output result_t                 result_o,
    input  logic                    fifo_ready_i
);

    iq_vec_t                alloc_onehot;
    iq_vec_t                issue_onehot;
    iq_vec_t                grant_onehot;
    iq_vec_t                slot_valid;
    iq_vec_t                slot_ready;
    exec_t [`IQ_SIZE-1:0]   slot_payload;
    logic                   pipe_advance;

    // ----------------------------------------------------------
    // control
    // ----------------------------------------------------------
    alu_iq_ctrl u_ctrl (
        .clk              (clk),
        .reset_i          (reset_i),
        .flush_i          (flush_i),
        .dispatch_valid_i (dispatch_valid_i),
        .fifo_ready_i     (fifo_ready_i),
        .valid_i          (slot_valid),
        .grant_i          (grant_onehot),
        .alloc_o          (alloc_onehot),
        .issue_o          (issue_onehot),
        .advance_o        (pipe_advance),
        .dispatch_ready_o (dispatch_ready_o),
        .wkup_valid_o     (wkup_valid_o),
        .result_valid_o   (result_valid_o)
    );

    // queue slots
    for (genvar i = 0; i < `IQ_SIZE; i++) begin : g_entry
        iq_entry u_entry (
            .clk        (clk),
            .reset_i    (reset_i),
            .flush_i    (flush_i),
            .alloc_i    (alloc_onehot[i]),
            .issue_i    (issue_onehot[i]),
            .dispatch_i (dispatch_i),
            .cdb_i      (cdb_i),
            .valid_o    (slot_valid[i]),
            .ready_o    (slot_ready[i]),
            .payload_o  (slot_payload[i])
        );
    end

    issue_select u_select (
        .clk     (clk),
        .reset_i (reset_i),
        .alloc_i (alloc_onehot),
        .valid_i (slot_valid),
        .ready_i (slot_ready),
        .grant_o (grant_onehot)
    );

    // ----------------------------------------------------------
    // execute pipe
    // ----------------------------------------------------------
    alu_exec u_exec (
        .clk        (clk),
        .reset_i    (reset_i),
        .flush_i    (flush_i),
        .issue_i    (issue_onehot),
        .advance_i  (pipe_advance),
        .payload_i  (slot_payload),
        .wkup_tag_o (wkup_tag_o),
        .result_o   (result_o)
    );

endmodule

//--- build.f
+incdir+.
alu_iq_pkg.sv
iq_entry.sv
issue_select.sv
alu_exec.sv
alu_iq_ctrl.sv
alu_iq_top.sv
tb_alu_iq.sv

//--- iq_entry.sv
`include "alu_iq_config.svh"

module iq_entry
    import alu_iq_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    flush_i,
    input  logic                    alloc_i,
    input  logic                    issue_i,
    input  dispatch_t               dispatch_i,
    input  cdb_t [`CDB_COUNT-1:0]   cdb_i,
    output logic                    valid_o,
    output logic                    ready_o,
    output exec_t                   payload_o
);

    logic          valid_q;
    alu_op_t       op_q;
    rob_id_t       dst_q;
    rob_id_t [1:0] tag_q;
    word_t   [1:0] val_q;
    logic    [1:0] rdy_q;

    // tag each source is waiting on this cycle
    rob_id_t [1:0] look_tag;
    logic    [1:0] hit;
    word_t   [1:0] hit_data;

    // ----------------------------------------------------------
    // cdb match, also covers the dispatch cycle
    // ----------------------------------------------------------
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            look_tag[s] = alloc_i ? dispatch_i.src_tag[s] : tag_q[s];
            hit[s]      = 1'b0;
            hit_data[s] = '0;
            for (int c = 0; c < `CDB_COUNT; c++) begin
                if (cdb_i[c].valid && (cdb_i[c].tag == look_tag[s])) begin
                    hit[s]      = 1'b1;
                    hit_data[s] = cdb_i[c].data;
                end
            end
        end
    end

    // occupancy
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (alloc_i) begin
            valid_q <= 1'b1;
        end else if (issue_i) begin
            valid_q <= 1'b0;
        end
    end

    // payload and operand capture
    always_ff @(posedge clk) begin
        if (alloc_i) begin
            op_q  <= dispatch_i.op;
            dst_q <= dispatch_i.dst;
            for (int s = 0; s < 2; s++) begin
                tag_q[s] <= dispatch_i.src_tag[s];
                rdy_q[s] <= dispatch_i.src_valid[s] || hit[s];
                val_q[s] <= dispatch_i.src_valid[s] ? dispatch_i.src_val[s] : hit_data[s];
            end
        end else if (valid_q) begin
            for (int s = 0; s < 2; s++) begin
                if (!rdy_q[s] && hit[s]) begin
                    rdy_q[s] <= 1'b1;
                    val_q[s] <= hit_data[s];
                end
            end
        end
    end

    assign valid_o = valid_q;
    assign ready_o = valid_q && (&rdy_q);

    assign payload_o.op  = op_q;
    assign payload_o.dst = dst_q;
    assign payload_o.opa = val_q[0];
    assign payload_o.opb = val_q[1];

    // ctrl must never pick a slot for both at once
    a_alloc_issue_excl: assert property (
        @(posedge clk) disable iff (reset_i)
        !(alloc_i && issue_i)
    );

endmodule

//--- issue_select.sv
`include "alu_iq_config.svh"

module issue_select
    import alu_iq_pkg::*;
(
    input  logic    clk,
    input  logic    reset_i,
    input  iq_vec_t alloc_i,
    input  iq_vec_t valid_i,
    input  iq_vec_t ready_i,
    output iq_vec_t grant_o
);

    // age_q[i][j] set means slot j is older than slot i
    iq_vec_t [`IQ_SIZE-1:0] age_q;
    iq_vec_t                req;

    // ----------------------------------------------------------
    // age matrix update
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            age_q <= '0;
        end else begin
            for (int i = 0; i < `IQ_SIZE; i++) begin
                for (int j = 0; j < `IQ_SIZE; j++) begin
                    if (alloc_i[i]) begin
                        // newcomer is younger than every live slot
                        age_q[i][j] <= valid_i[j] && (i != j);
                    end else if (alloc_i[j]) begin
                        age_q[i][j] <= 1'b0;
                    end
                end
            end
        end
    end

    // ----------------------------------------------------------
    // oldest ready wins
    // ----------------------------------------------------------
    assign req = valid_i & ready_i;

    always_comb begin
        for (int i = 0; i < `IQ_SIZE; i++) begin
            grant_o[i] = req[i] && !(|(age_q[i] & req));
        end
    end

    // relies on the matrix staying a strict order over time
    a_grant_onehot: assert property (
        @(posedge clk) disable iff (reset_i)
        $onehot0(grant_o)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f build.f --top-module tb_alu_iq -o sim_alu_iq

out=$(./obj_dir/sim_alu_iq)
echo "$out"

if echo "$out" | grep -q '\*\* PASS \*\*'; then
    exit 0
else
    exit 1
fi

//--- tb_alu_iq.sv
`include "alu_iq_config.svh"

module tb_alu_iq
    import alu_iq_pkg::*;
();

    localparam int LIMIT = (8 + 4 + 5 + 8 + 6 + 200) * 8 + 200;

    logic clk;
    logic reset_i;
    logic flush_i;
    logic dispatch_valid_i;
    dispatch_t dispatch_i;
    logic dispatch_ready_o;
    cdb_t [`CDB_COUNT-1:0] cdb_i;
    logic wkup_valid_o;
    rob_id_t wkup_tag_o;
    logic result_valid_o;
    result_t result_o;
    logic fifo_ready_i;

    // scoreboard indexed by dst tag
    word_t exp_data [32];
    logic [31:0] exp_live;
    int live_count;
    rob_id_t wq[$];
    rob_id_t got_q[$];
    logic hold_prev;
    result_t prev_res;
    logic [31:0] lfsr;
    int errors, ntests, err_at_start, cycles;
    string cur_test;
    rob_id_t next_dst, next_ptag;

    alu_iq_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // expected alu behavior
    function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic dispatch_t mk(input alu_op_t op, input rob_id_t t0, input word_t v0,
                                     input logic r0, input rob_id_t t1, input word_t v1,
                                     input logic r1);
        dispatch_t d;
        d.op = op;
        d.dst = next_dst;
        d.src_tag[0] = t0;
        d.src_tag[1] = t1;
        // junk in waiting operands so a missed capture shows up
        d.src_val[0] = r0 ? v0 : ~v0;
        d.src_val[1] = r1 ? v1 : ~v1;
        d.src_valid = {r1, r0};
        exp_data[d.dst] = alu_ref(op, v0, v1);
        exp_live[d.dst] = 1'b1;
        live_count++;
        next_dst = rob_id_t'((next_dst + 1) % 16);
        return d;
    endfunction

    function automatic cdb_t bc(input rob_id_t t, input word_t v);
        return {1'b1, t, v};
    endfunction

    function automatic rob_id_t new_ptag();
        rob_id_t t;
        t = next_ptag;
        next_ptag = (next_ptag == 5'd31) ? 5'd16 : rob_id_t'(next_ptag + 1);
        return t;
    endfunction

    task automatic check_result(input string name, input result_t exp, input result_t act);
        if (exp !== act) begin
            $display("Mismatch %s %s: expected %h, actual %h", cur_test, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_tag(input string name, input rob_id_t exp, input rob_id_t act);
        if (exp !== act) begin
            $display("Mismatch %s %s: expected %0d, actual %0d", cur_test, name, exp, act);
            errors++;
        end
    endtask

    task automatic fail(input string msg);
        $display("%s: %s", cur_test, msg);
        errors++;
    endtask

    // one dispatch slot plus optional cdb broadcasts in the same cycle
    task automatic do_cycle(input logic dv, input dispatch_t d, input cdb_t c0, input cdb_t c1);
        if (dv) begin
            @(negedge clk);
            while (!dispatch_ready_o) begin
                @(posedge clk);
                fifo_ready_i <= 1'b1;
                @(negedge clk);
            end
        end
        @(posedge clk);
        dispatch_valid_i <= dv;
        dispatch_i <= d;
        cdb_i[0] <= c0;
        cdb_i[1] <= c1;
        @(posedge clk);
        dispatch_valid_i <= 1'b0;
        cdb_i <= '0;
    endtask

    task automatic drain();
        while (live_count != 0) @(posedge clk);
    endtask

    task automatic start_test(input string n);
        cur_test = n;
        err_at_start = errors;
        got_q.delete();
    endtask

    task automatic end_test();
        ntests++;
        $display("test %s: %s", cur_test, (errors == err_at_start) ? "ok" : "failed");
    endtask

    // ----------------------------------------------------------
    // result monitor and scoreboard
    // ----------------------------------------------------------
    always @(negedge clk) begin
        if (reset_i || flush_i) begin
            hold_prev = 1'b0;
        end else begin
            if (hold_prev) begin
                if (!result_valid_o) fail("result_valid_o dropped under back-pressure");
                else check_result("held result", prev_res, result_o);
            end
            if (wkup_valid_o) wq.push_back(wkup_tag_o);
            if (result_valid_o && fifo_ready_i) begin
                if (wq.size() == 0) fail("result without an earlier wakeup");
                else check_tag("wakeup order", wq.pop_front(), result_o.dst);
                if (!exp_live[result_o.dst]) begin
                    fail($sformatf("unexpected or duplicate result tag %0d", result_o.dst));
                end else begin
                    check_result("result", {result_o.dst, exp_data[result_o.dst]}, result_o);
                    exp_live[result_o.dst] = 1'b0;
                    live_count--;
                end
                got_q.push_back(result_o.dst);
            end
            hold_prev = result_valid_o && !fifo_ready_i;
            prev_res = result_o;
        end
    end

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout after %0d cycles in test %s", cycles, cur_test);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        dispatch_t d;
        cdb_t pend;
        rob_id_t pt, pt1, exp_order[$];
        word_t x;
        logic w0, w1;
        reset_i = 1'b1;
        flush_i = 1'b0;
        dispatch_valid_i = 1'b0;
        dispatch_i = '0;
        cdb_i = '0;
        fifo_ready_i = 1'b1;
        lfsr = 32'h562a_f844;
        exp_live = '0;
        live_count = 0;
        hold_prev = 1'b0;
        errors = 0;
        ntests = 0;
        cycles = 0;
        next_dst = '0;
        next_ptag = 5'd16;
        cur_test = "reset";
        repeat (16) @(posedge clk);
        reset_i <= 1'b0;

        start_test("all_ops");
        exp_order.delete();
        for (int op = 0; op < 8; op++) begin
            exp_order.push_back(next_dst);
            d = mk(alu_op_t'(op), '0, rand_bits(32), 1'b1, '0, rand_bits(32), 1'b1);
            do_cycle(1'b1, d, '0, '0);
        end
        drain();
        foreach (exp_order[i]) check_tag("dispatch order", exp_order[i], got_q[i]);
        end_test();

        start_test("cdb_wakeup");
        pt = new_ptag();
        x = rand_bits(32);
        exp_order = '{next_dst + 5'd1, next_dst};
        d = mk(ALU_SUB, pt, x, 1'b0, '0, 32'd7, 1'b1);
        do_cycle(1'b1, d, '0, '0);
        d = mk(ALU_XOR, '0, rand_bits(32), 1'b1, '0, rand_bits(32), 1'b1);
        do_cycle(1'b1, d, '0, '0);
        repeat (4) @(negedge clk);
        do_cycle(1'b0, '0, '0, bc(pt, x));
        pt = new_ptag();
        x = rand_bits(32);
        exp_order.push_back(next_dst);
        d = mk(ALU_SLT, '0, 32'hffff_fff0, 1'b1, pt, x, 1'b0);
        do_cycle(1'b1, d, bc(pt, x), '0);
        drain();
        foreach (exp_order[i]) check_tag("issue order", exp_order[i], got_q[i]);
        end_test();

        start_test("full_backpressure");
        @(posedge clk);
        fifo_ready_i <= 1'b0;
        pt = new_ptag();
        pt1 = new_ptag();
        x = rand_bits(32);
        exp_order.delete();
        // first entry issues early and its slot 0 is refilled by a younger entry
        for (int i = 0; i < 5; i++) begin
            exp_order.push_back(next_dst);
            d = mk(alu_op_t'(rand_bits(3)), (i == 0) ? pt1 : pt, x, 1'b0,
                   '0, rand_bits(32), 1'b1);
            do_cycle(1'b1, d, (i == 1) ? bc(pt1, x) : '0, '0);
        end
        @(negedge clk);
        if (dispatch_ready_o) fail("dispatch_ready_o stayed high with a full queue");
        do_cycle(1'b0, '0, '0, bc(pt, x));
        while (!result_valid_o) @(negedge clk);
        repeat (6) @(negedge clk);
        @(posedge clk);
        fifo_ready_i <= 1'b1;
        drain();
        if (got_q.size() != 5) fail($sformatf("%0d results instead of 5", got_q.size()));
        foreach (exp_order[i]) check_tag("age order", exp_order[i], got_q[i]);
        end_test();

        start_test("early_wakeup");
        for (int i = 0; i < 8; i++) begin
            fifo_ready_i <= i[0];
            d = mk(alu_op_t'(rand_bits(3)), '0, rand_bits(32), 1'b1, '0, rand_bits(32), 1'b1);
            do_cycle(1'b1, d, '0, '0);
        end
        fifo_ready_i <= 1'b1;
        drain();
        if (wq.size() != 0) fail("wakeup tags left with no matching result");
        end_test();

        start_test("flush");
        fifo_ready_i <= 1'b0;
        for (int i = 0; i < 3; i++) begin
            d = mk(ALU_ADD, '0, rand_bits(32), 1'b1, '0, rand_bits(32), 1'b1);
            do_cycle(1'b1, d, '0, '0);
        end
        @(posedge clk);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        fifo_ready_i <= 1'b1;
        exp_live = '0;
        live_count = 0;
        wq.delete();
        @(negedge clk);
        if (!dispatch_ready_o) fail("dispatch_ready_o low after flush");
        repeat (6) begin
            if (result_valid_o) fail("stale result after flush");
            @(negedge clk);
        end
        for (int i = 0; i < 3; i++) begin
            d = mk(ALU_OR, '0, rand_bits(32), 1'b1, '0, rand_bits(32), 1'b1);
            do_cycle(1'b1, d, '0, '0);
        end
        drain();
        end_test();

        start_test("random_mix");
        pend = '0;
        for (int i = 0; i < 200; i++) begin
            x = rand_bits(32);
            w0 = (rand_bits(2) == 0);
            w1 = (rand_bits(2) == 0);
            pt = new_ptag();
            pt1 = new_ptag();
            fifo_ready_i <= (rand_bits(2) != 0);
            d = mk(alu_op_t'(rand_bits(3)), pt, x, !w0, pt1, rand_bits(32), !w1);
            // src1 broadcast is held back to the next slot
            do_cycle(1'b1, d, w0 ? bc(pt, x) : '0, pend);
            pend = w1 ? bc(pt1, ~d.src_val[1]) : '0;
        end
        do_cycle(1'b0, '0, '0, pend);
        fifo_ready_i <= 1'b1;
        drain();
        end_test();

        $display("tests %0d, errors %0d", ntests, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
